//--- dram_read_mux.f
+incdir+src
src/axi4_pkg.sv
src/dram_mux_pkg.sv
src/reset_pipe.sv
src/ar_arbiter.sv
src/order_fifo.sv
src/r_router.sv
src/dram_read_mux.sv
tb/dram_read_mux_tb.sv

//--- run.sh
#!/bin/sh
# build and run the dram read mux testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module dram_read_mux_tb -f dram_read_mux.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vdram_read_mux_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "Simulation passed"; then
  exit 0
fi
exit 1

//--- src/ar_arbiter.sv
// --------------------------------------
// round-robin ar arbiter
// picks one slot, holds the request in a
// one-entry register toward dram
// --------------------------------------
`include "dram_mux_macros.svh"

module ar_arbiter (
  input  logic                                 clk_i
  ,input  logic                                 rst_n_i
  ,input  axi4_pkg::ar_req_t [`DMUX_SLOTS-1:0]  slot_ar_i
  ,input  logic [`DMUX_SLOTS-1:0]               slot_arvalid_i
  ,output logic [`DMUX_SLOTS-1:0]               slot_arready_o
  ,input  logic                                 fifo_full_i
  ,output axi4_pkg::ar_req_t                    dram_ar_o
  ,output logic                                 dram_arvalid_o
  ,input  logic                                 dram_arready_i
  ,output logic                                 grant_v_o
  ,output dram_mux_pkg::slot_e                  grant_slot_o
);

  logic                run_q;
  logic                ar_v_q;
  axi4_pkg::ar_req_t   ar_q;
  dram_mux_pkg::slot_e last_q;
  dram_mux_pkg::slot_e pick;
  logic                slot_open;
  logic                grant;

  // --------------------------------------
  // slot selection
  // --------------------------------------
  always_comb begin
    pick = dram_mux_pkg::SLOT_MC;
    if (slot_arvalid_i[0] && slot_arvalid_i[1]) begin
      // tie goes to the slot not granted last
      pick = (last_q == dram_mux_pkg::SLOT_MC) ? dram_mux_pkg::SLOT_PCIS
                                               : dram_mux_pkg::SLOT_MC;
    end else if (slot_arvalid_i[1]) begin
      pick = dram_mux_pkg::SLOT_PCIS;
    end
  end

  // register empty or draining, and room in the ordering record
  assign slot_open = run_q && !fifo_full_i && (!ar_v_q || dram_arready_i);
  assign grant     = slot_open && slot_arvalid_i[pick];

  for (genvar g = 0; g < `DMUX_SLOTS; g++) begin : g_ready
    assign slot_arready_o[g] = slot_open && (pick == dram_mux_pkg::slot_e'(g));
  end

  // --------------------------------------
  // output register
  // --------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      run_q  <= 1'b0;
      ar_v_q <= 1'b0;
      last_q <= dram_mux_pkg::SLOT_PCIS;
    end else begin
      run_q <= 1'b1;
      if (grant) begin
        ar_v_q <= 1'b1;
        last_q <= pick;
      end else if (dram_arready_i) begin
        ar_v_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (grant) begin
      ar_q <= slot_ar_i[pick];
    end
  end

  assign dram_ar_o      = ar_q;
  assign dram_arvalid_o = ar_v_q;
  assign grant_v_o      = grant;
  assign grant_slot_o   = pick;

  // request must hold until dram takes it
  a_ar_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dram_arvalid_o && !dram_arready_i |=> dram_arvalid_o && $stable(dram_ar_o));

endmodule : ar_arbiter

//--- src/axi4_pkg.sv
// --------------------------------------
// axi4 read channel types
// address request and read data beat
// --------------------------------------
`include "dram_mux_macros.svh"

package axi4_pkg;

  // ar channel payload, valid/ready travel separately
  typedef struct packed {
    logic [`DMUX_ID_W-1:0]   arid;
    logic [`DMUX_ADDR_W-1:0] araddr;
    logic [`DMUX_LEN_W-1:0]  arlen;
    logic [2:0]              arsize;
    logic [1:0]              arburst;
  } ar_req_t;

  // r channel payload
  typedef struct packed {
    logic [`DMUX_ID_W-1:0]   rid;
    logic [`DMUX_DATA_W-1:0] rdata;
    logic [1:0]              rresp;
    logic                    rlast;
  } r_beat_t;

endpackage : axi4_pkg

//--- src/dram_mux_macros.svh
// --------------------------------------
// dram read mux parameters
// widths, slot count, ordering depth and
// reset pipe length
// --------------------------------------
`ifndef DRAM_MUX_MACROS_SVH
`define DRAM_MUX_MACROS_SVH

// axi4 field widths
`define DMUX_ADDR_W 32
`define DMUX_DATA_W 32
`define DMUX_ID_W 4
`define DMUX_LEN_W 8

// slot 0 is manycore memsys, slot 1 is host pcis
`define DMUX_SLOTS 2

// most bursts in flight toward dram
`define DMUX_ORDER_DEPTH 4
`define DMUX_RST_STAGES 4

`endif

//--- src/dram_mux_pkg.sv
// --------------------------------------
// dram read mux types
// slot identity and ordering record
// --------------------------------------
`include "dram_mux_macros.svh"

package dram_mux_pkg;

  // also the round-robin priority state
  typedef enum logic {
    SLOT_MC   = 1'b0,
    SLOT_PCIS = 1'b1
  } slot_e;

  // ordering fifo pointer and occupancy
  typedef logic [$clog2(`DMUX_ORDER_DEPTH)-1:0]   order_ptr_t;
  typedef logic [$clog2(`DMUX_ORDER_DEPTH+1)-1:0] order_cnt_t;

endpackage : dram_mux_pkg

//--- src/dram_read_mux.sv
// --------------------------------------
// dram read mux top
// shares one dram ar/r port between the
// manycore and host pcis read masters
// --------------------------------------
`include "dram_mux_macros.svh"

module dram_read_mux (
  input  logic                                clk_i
  ,input  logic                                arst_n_i
  // slot ar
  ,input  axi4_pkg::ar_req_t [`DMUX_SLOTS-1:0] slot_ar_i
  ,input  logic [`DMUX_SLOTS-1:0]              slot_arvalid_i
  ,output logic [`DMUX_SLOTS-1:0]              slot_arready_o
  // slot r
  ,output axi4_pkg::r_beat_t [`DMUX_SLOTS-1:0] slot_r_o
  ,output logic [`DMUX_SLOTS-1:0]              slot_rvalid_o
  ,input  logic [`DMUX_SLOTS-1:0]              slot_rready_i
  // dram side
  ,output axi4_pkg::ar_req_t                   dram_ar_o
  ,output logic                                dram_arvalid_o
  ,input  logic                                dram_arready_i
  ,input  axi4_pkg::r_beat_t                   dram_r_i
  ,input  logic                                dram_rvalid_i
  ,output logic                                dram_rready_o
);

  logic                rst_n;
  logic                grant_v;
  dram_mux_pkg::slot_e grant_slot;
  dram_mux_pkg::slot_e head_slot;
  logic                head_v;
  logic                fifo_full;
  logic                pop;

  reset_pipe u_reset_pipe (
    .clk_i   (clk_i   )
    ,.arst_n_i(arst_n_i)
    ,.rst_n_o (rst_n   )
  );

  ar_arbiter u_ar_arbiter (
    .clk_i         (clk_i         )
    ,.rst_n_i       (rst_n         )
    ,.slot_ar_i     (slot_ar_i     )
    ,.slot_arvalid_i(slot_arvalid_i)
    ,.slot_arready_o(slot_arready_o)
    ,.fifo_full_i   (fifo_full     )
    ,.dram_ar_o     (dram_ar_o     )
    ,.dram_arvalid_o(dram_arvalid_o)
    ,.dram_arready_i(dram_arready_i)
    ,.grant_v_o     (grant_v       )
    ,.grant_slot_o  (grant_slot    )
  );

  order_fifo u_order_fifo (
    .clk_i      (clk_i     )
    ,.rst_n_i    (rst_n     )
    ,.push_i     (grant_v   )
    ,.push_slot_i(grant_slot)
    ,.pop_i      (pop       )
    ,.head_slot_o(head_slot )
    ,.head_v_o   (head_v    )
    ,.full_o     (fifo_full )
  );

  r_router u_r_router (
    .clk_i        (clk_i        )
    ,.dram_r_i     (dram_r_i     )
    ,.dram_rvalid_i(dram_rvalid_i)
    ,.dram_rready_o(dram_rready_o)
    ,.head_slot_i  (head_slot    )
    ,.head_v_i     (head_v       )
    ,.slot_r_o     (slot_r_o     )
    ,.slot_rvalid_o(slot_rvalid_o)
    ,.slot_rready_i(slot_rready_i)
    ,.pop_o        (pop          )
  );

endmodule : dram_read_mux

//--- src/order_fifo.sv
// --------------------------------------
// ordering record of outstanding bursts
// one slot identity per accepted ar
// --------------------------------------
`include "dram_mux_macros.svh"

module order_fifo (
  input  logic                 clk_i
  ,input  logic                 rst_n_i
  ,input  logic                 push_i
  ,input  dram_mux_pkg::slot_e  push_slot_i
  ,input  logic                 pop_i
  ,output dram_mux_pkg::slot_e  head_slot_o
  ,output logic                 head_v_o
  ,output logic                 full_o
);

  dram_mux_pkg::slot_e     mem_q [`DMUX_ORDER_DEPTH];
  dram_mux_pkg::order_ptr_t wr_ptr_q;
  dram_mux_pkg::order_ptr_t rd_ptr_q;
  dram_mux_pkg::order_cnt_t count_q;

  localparam dram_mux_pkg::order_ptr_t LastPtr =
    dram_mux_pkg::order_ptr_t'(`DMUX_ORDER_DEPTH - 1);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == LastPtr) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == LastPtr) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_slot_i;
    end
  end

  assign head_slot_o = mem_q[rd_ptr_q];
  assign head_v_o    = (count_q != '0);
  assign full_o      = (count_q == dram_mux_pkg::order_cnt_t'(`DMUX_ORDER_DEPTH));

  // arbiter holds off when full
  a_no_overflow : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> !full_o);

  // rlast only for a recorded burst
  a_no_underflow : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> head_v_o);

endmodule : order_fifo

//--- src/r_router.sv
// --------------------------------------
// read data router
// steers dram beats to the head slot,
// retires the burst on rlast
// --------------------------------------
`include "dram_mux_macros.svh"

module r_router (
  input  logic                                clk_i
  ,input  axi4_pkg::r_beat_t                   dram_r_i
  ,input  logic                                dram_rvalid_i
  ,output logic                                dram_rready_o
  ,input  dram_mux_pkg::slot_e                 head_slot_i
  ,input  logic                                head_v_i
  ,output axi4_pkg::r_beat_t [`DMUX_SLOTS-1:0] slot_r_o
  ,output logic [`DMUX_SLOTS-1:0]              slot_rvalid_o
  ,input  logic [`DMUX_SLOTS-1:0]              slot_rready_i
  ,output logic                                pop_o
);

  logic r_xfer;

  for (genvar g = 0; g < `DMUX_SLOTS; g++) begin : g_slot
    assign slot_r_o[g]      = dram_r_i;
    assign slot_rvalid_o[g] = dram_rvalid_i && head_v_i &&
                              (head_slot_i == dram_mux_pkg::slot_e'(g));
  end

  // owner's ready goes straight back to dram
  assign dram_rready_o = head_v_i && slot_rready_i[head_slot_i];
  assign r_xfer        = dram_rvalid_i && dram_rready_o;
  assign pop_o         = r_xfer && dram_r_i.rlast;

  // dram answers only bursts it was given
  a_r_owned : assert property (@(posedge clk_i) dram_rvalid_i |-> head_v_i);

endmodule : r_router

//--- src/reset_pipe.sv
// --------------------------------------
// reset synchronizer
// asserts at once, releases after a
// fixed number of clock edges
// --------------------------------------
`include "dram_mux_macros.svh"

module reset_pipe (
  input  logic clk_i
  ,input  logic arst_n_i
  ,output logic rst_n_o
);

  logic [`DMUX_RST_STAGES-1:0] sync_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q <= '0;
    end else begin
      // shift ones in after release
      sync_q <= {sync_q[`DMUX_RST_STAGES-2:0], 1'b1};
    end
  end

  assign rst_n_o = sync_q[`DMUX_RST_STAGES-1];

endmodule : reset_pipe

//--- tb/dram_read_mux_tb.sv
// --------------------------------------
// dram read mux testbench
// two read masters and an in-order dram
// model, both with random stalls
// --------------------------------------
`include "dram_mux_macros.svh"

module dram_read_mux_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MaxTests = 64;

  logic                                clk_i;
  logic                                arst_n_i;
  axi4_pkg::ar_req_t [`DMUX_SLOTS-1:0] slot_ar_i;
  logic [`DMUX_SLOTS-1:0]              slot_arvalid_i;
  logic [`DMUX_SLOTS-1:0]              slot_arready_o;
  axi4_pkg::r_beat_t [`DMUX_SLOTS-1:0] slot_r_o;
  logic [`DMUX_SLOTS-1:0]              slot_rvalid_o;
  logic [`DMUX_SLOTS-1:0]              slot_rready_i;
  axi4_pkg::ar_req_t                   dram_ar_o;
  logic                                dram_arvalid_o;
  logic                                dram_arready_i;
  axi4_pkg::r_beat_t                   dram_r_i;
  logic                                dram_rvalid_i;
  logic                                dram_rready_o;

  // four words per request: slot, addr, arlen, gap
  logic [31:0]            tests_mem [4*MaxTests];
  int                     n_tests;
  int                     limit;
  int                     cycles;
  int                     checks;
  int                     errors;
  int                     bursts_done;
  int                     outstanding;
  int                     max_outstanding;
  int                     n_dram_ar;
  logic [31:0]            rnd;
  int                     slot_tests [`DMUX_SLOTS][$];
  int                     wait_cnt [`DMUX_SLOTS];
  logic [`DMUX_SLOTS-1:0] sent;
  axi4_pkg::ar_req_t      ar_pend [`DMUX_SLOTS][$];
  axi4_pkg::ar_req_t      r_pend [`DMUX_SLOTS][$];
  int                     slot_k [`DMUX_SLOTS];
  axi4_pkg::ar_req_t      dram_q [$];
  int                     dram_k;

  dram_read_mux uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // arid carries the slot in its top bit
  function automatic axi4_pkg::ar_req_t test_req(input int n);
    axi4_pkg::ar_req_t req;
    req.arid    = {tests_mem[4*n][0], 3'(n)};
    req.araddr  = tests_mem[4*n+1];
    req.arlen   = tests_mem[4*n+2][7:0];
    req.arsize  = 3'd2;
    req.arburst = 2'b01;
    return req;
  endfunction

  // beat k: address plus k, rlast on beat arlen
  function automatic axi4_pkg::r_beat_t beat_of(input axi4_pkg::ar_req_t req, input int k);
    axi4_pkg::r_beat_t b;
    b.rid   = req.arid;
    b.rdata = req.araddr + 32'(k);
    b.rresp = 2'b00;
    b.rlast = (k == int'(req.arlen));
    return b;
  endfunction

  task automatic report_error(input string msg);
    errors++;
    $display("ERROR: %s", msg);
  endtask

  task automatic check_ar(input axi4_pkg::ar_req_t exp, input axi4_pkg::ar_req_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL dram_ar_o expected %h actual %h", exp, act);
    end
  endtask

  task automatic check_r(input string name, input axi4_pkg::r_beat_t exp,
                         input axi4_pkg::r_beat_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_slot(input dram_mux_pkg::slot_e exp, input dram_mux_pkg::slot_e act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL dram_ar_o.arid slot expected %h actual %h", exp, act);
    end
  endtask

  task automatic check_ctrl(input string name, input logic [1:0] exp, input logic [1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_quiet();
    check_ctrl("dram_arvalid_o", 2'b00, {1'b0, dram_arvalid_o});
    check_ctrl("slot_arready_o", 2'b00, slot_arready_o);
    check_ctrl("slot_rvalid_o", 2'b00, slot_rvalid_o);
  endtask

  // --------------------------------------
  // handshakes seen just before the edge
  // --------------------------------------
  task automatic sample_handshakes();
    axi4_pkg::ar_req_t req;
    axi4_pkg::r_beat_t exp;
    int                s;
    for (int i = 0; i < `DMUX_SLOTS; i++) begin
      if (slot_arvalid_i[i] && slot_arready_o[i]) begin
        ar_pend[i].push_back(slot_ar_i[i]);
        r_pend[i].push_back(slot_ar_i[i]);
        slot_tests[i].delete(0);
        sent[i] = 1'b1;
        if (slot_tests[i].size() > 0)
          wait_cnt[i] = int'(tests_mem[4*slot_tests[i][0]+3]);
      end
    end
    // dram model retires before it accepts
    if (dram_rvalid_i && dram_rready_o) begin
      if (dram_r_i.rlast) begin
        dram_q.delete(0);
        dram_k = 0;
        outstanding--;
      end else begin
        dram_k++;
      end
    end
    if (dram_arvalid_o && dram_arready_i) begin
      s = int'(dram_ar_o.arid[3]);
      if (ar_pend[s].size() == 0) begin
        report_error("dram AR accepted with no matching slot request");
      end else begin
        req = ar_pend[s].pop_front();
        check_ar(req, dram_ar_o);
      end
      if (n_dram_ar < 2)
        check_slot((n_dram_ar == 0) ? dram_mux_pkg::SLOT_MC : dram_mux_pkg::SLOT_PCIS,
                   dram_mux_pkg::slot_e'(dram_ar_o.arid[3]));
      n_dram_ar++;
      dram_q.push_back(dram_ar_o);
      outstanding++;
      if (outstanding > max_outstanding)
        max_outstanding = outstanding;
      if (outstanding > `DMUX_ORDER_DEPTH)
        report_error("too many bursts outstanding at the dram port");
    end
    if (&slot_rvalid_o)
      report_error("rvalid high at both slots at once");
    for (int i = 0; i < `DMUX_SLOTS; i++) begin
      if (slot_rvalid_o[i] && slot_rready_i[i]) begin
        if (r_pend[i].size() == 0) begin
          report_error($sformatf("beat at slot %0d with no burst outstanding", i));
        end else begin
          exp = beat_of(r_pend[i][0], slot_k[i]);
          check_r($sformatf("slot_r_o[%0d]", i), exp, slot_r_o[i]);
          if (exp.rlast) begin
            r_pend[i].delete(0);
            slot_k[i] = 0;
            bursts_done++;
          end else begin
            slot_k[i]++;
          end
        end
      end
    end
  endtask

  // --------------------------------------
  // falling edge stimulus
  // --------------------------------------
  task automatic drive_inputs();
    rnd            = lcg_next(rnd);
    dram_arready_i = (rnd[17:16] != 2'b00);
    rnd            = lcg_next(rnd);
    slot_rready_i  = {rnd[20:19] != 2'b00, rnd[18:17] != 2'b00};
    dram_rvalid_i  = (dram_q.size() > 0);
    if (dram_q.size() > 0)
      dram_r_i = beat_of(dram_q[0], dram_k);
    for (int i = 0; i < `DMUX_SLOTS; i++) begin
      if (sent[i]) begin
        slot_arvalid_i[i] = 1'b0;
        sent[i]           = 1'b0;
      end
      if (!slot_arvalid_i[i] && slot_tests[i].size() > 0) begin
        if (wait_cnt[i] == 0) begin
          slot_ar_i[i]      = test_req(slot_tests[i][0]);
          slot_arvalid_i[i] = 1'b1;
        end else begin
          wait_cnt[i]--;
        end
      end
    end
  endtask

  initial begin
    arst_n_i        = 1'b1;
    slot_ar_i       = '0;
    slot_arvalid_i  = '0;
    slot_rready_i   = '0;
    dram_arready_i  = 1'b0;
    dram_r_i        = '0;
    dram_rvalid_i   = 1'b0;
    sent            = '0;
    rnd             = 32'd44021;
    dram_k          = 0;
    slot_k          = '{0, 0};
    wait_cnt        = '{0, 0};
    cycles          = 0;
    checks          = 0;
    errors          = 0;
    bursts_done     = 0;
    outstanding     = 0;
    max_outstanding = 0;
    n_dram_ar       = 0;
    n_tests         = 0;
    limit           = 200;
    for (int w = 0; w < 4*MaxTests; w++)
      tests_mem[w] = 32'hff;
    $readmemh("tb/dram_read_mux_tests.txt", tests_mem);
    while (n_tests < MaxTests && tests_mem[4*n_tests] != 32'hff) begin
      slot_tests[tests_mem[4*n_tests][0]].push_back(n_tests);
      limit += (int'(tests_mem[4*n_tests+3]) + int'(tests_mem[4*n_tests+2]) + 1) * 8;
      n_tests++;
    end
    for (int i = 0; i < `DMUX_SLOTS; i++) begin
      if (slot_tests[i].size() > 0)
        wait_cnt[i] = int'(tests_mem[4*slot_tests[i][0]+3]);
    end

    #1 arst_n_i = 1'b0;
    repeat (2) begin
      @(posedge clk_i);
      check_quiet();
    end
    @(negedge clk_i);
    arst_n_i = 1'b1;

    while (bursts_done < n_tests && cycles < limit) begin
      drive_inputs();
      // settle, then look at what the next rising edge will take
      #1;
      cycles++;
      if (cycles <= `DMUX_RST_STAGES)
        check_quiet();
      sample_handshakes();
      @(negedge clk_i);
    end
    if (bursts_done < n_tests)
      report_error($sformatf("timeout after %0d cycles, %0d of %0d bursts done",
                             cycles, bursts_done, n_tests));

    $display("checks %0d errors %0d bursts %0d max outstanding %0d",
             checks, errors, bursts_done, max_outstanding);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule : dram_read_mux_tb

//--- tb/dram_read_mux_tests.txt
// slot addr arlen gap, all hex, one read request per line
// slot 0 is manycore, slot 1 is host pcis, slot ff ends the list
0 00001000 03 00
1 80000000 01 00
0 00001100 00 00
0 00001200 07 00
1 80000040 02 00
1 80000080 00 00
0 00002000 01 05
1 80001000 03 02
0 00002400 00 00
1 80001100 05 0a
0 00003000 02 01
1 80002000 00 00
0 00003100 0f 03
1 80002200 01 00
ff 00000000 00 00
